/* logic/chip8_defs.svh */
`ifndef CHIP8_DEFS_SVH
`define CHIP8_DEFS_SVH

// memory and pc address width
`define CHIP8_ADDR_W   12

// register and memory byte width
`define CHIP8_DATA_W   8

`define CHIP8_NUM_V    16

// programs start above the interpreter area
`define CHIP8_PC_RESET 12'h200

`define CHIP8_FLAG_REG 4'hF

`endif

/* logic/chip8_pkg.sv */
package chip8_pkg;

`include "chip8_defs.svh"

   typedef logic [`CHIP8_ADDR_W-1:0]        addr_t;
   typedef logic [`CHIP8_DATA_W-1:0]        byte_t;
   typedef logic [$clog2(`CHIP8_NUM_V)-1:0] vidx_t;

   // one instruction word, seen as nibbles or as x plus immediate byte
   typedef union packed {
      struct packed {
         logic [3:0] op;
         vidx_t      x;
         vidx_t      y;
         logic [3:0] n;
      } nib;
      struct packed {
         logic [3:0] op;
         vidx_t      x;
         byte_t      kk;
      } imm;
   } instr_u;

   // 8xy group, selected by n
   typedef enum logic [3:0] {
      ALU_MOV  = 4'h0,
      ALU_OR   = 4'h1,
      ALU_AND  = 4'h2,
      ALU_XOR  = 4'h3,
      ALU_ADD  = 4'h4,
      ALU_SUB  = 4'h5,
      ALU_SHR  = 4'h6,
      ALU_SUBN = 4'h7,
      ALU_SHL  = 4'hE
   } alu_op_e;

endpackage

/* logic/operand_if.sv */
`timescale 1ns/100ps

interface operand_if;

   logic              issue;  // one cycle per instruction
   chip8_pkg::instr_u instr;
   chip8_pkg::byte_t  vx;
   chip8_pkg::byte_t  vy;

   modport issuer (
      output issue,
      output instr,
      output vx,
      output vy
   );

   modport exec (
      input issue,
      input instr,
      input vx,
      input vy
   );

endinterface

/* logic/program_mem.sv */
`timescale 1ns/100ps

`include "chip8_defs.svh"

module program_mem (
   input  logic             clk,
   input  logic             load_we,
   input  chip8_pkg::addr_t load_addr,
   input  chip8_pkg::byte_t load_data,
   input  chip8_pkg::addr_t raddr,
   output chip8_pkg::byte_t rdata
);

   chip8_pkg::byte_t mem [0:(1 << `CHIP8_ADDR_W)-1];

   always_ff @(posedge clk)
   begin
      if (load_we)
      begin
         mem[load_addr] <= load_data;
      end
   end

   // data one cycle after the address
   always_ff @(posedge clk)
   begin
      rdata <= mem[raddr];
   end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/100ps

`include "chip8_defs.svh"

module reg_file (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             we,
   input  chip8_pkg::vidx_t waddr,
   input  chip8_pkg::byte_t wdata,
   input  chip8_pkg::vidx_t raddr_a,
   input  chip8_pkg::vidx_t raddr_b,
   output chip8_pkg::byte_t rdata_a,
   output chip8_pkg::byte_t rdata_b
);

   chip8_pkg::byte_t v [`CHIP8_NUM_V];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < `CHIP8_NUM_V; i++)
         begin
            v[i] <= '0;
         end
      end
      else if (we)
      begin
         v[waddr] <= wdata;
      end
   end

   assign rdata_a = v[raddr_a];
   assign rdata_b = v[raddr_b];

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             run,
   input  chip8_pkg::addr_t pc,
   input  logic             retire,
   output chip8_pkg::addr_t mem_raddr,
   input  chip8_pkg::byte_t mem_rdata,
   output chip8_pkg::vidx_t vx_idx,
   output chip8_pkg::vidx_t vy_idx,
   input  chip8_pkg::byte_t vx_data,
   input  chip8_pkg::byte_t vy_data,
   operand_if.issuer        ops
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH_HI,
      S_FETCH_LO,
      S_READ,
      S_ISSUE,
      S_WAIT
   } state_e;

   state_e            state;
   chip8_pkg::byte_t  hi_byte;
   chip8_pkg::instr_u cur_instr;

   assign mem_raddr = (state == S_FETCH_LO) ? pc + chip8_pkg::addr_t'(1) : pc;
   assign cur_instr = {hi_byte, mem_rdata};  // valid in S_READ
   assign vx_idx    = cur_instr.nib.x;
   assign vy_idx    = cur_instr.nib.y;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= S_IDLE;
         ops.issue <= 1'b0;
      end
      else
      begin
         ops.issue <= (state == S_READ);
         case (state)
            S_IDLE:     state <= run ? S_FETCH_HI : S_IDLE;
            S_FETCH_HI: state <= S_FETCH_LO;
            S_FETCH_LO: state <= S_READ;
            S_READ:     state <= S_ISSUE;
            S_ISSUE:    state <= S_WAIT;
            S_WAIT:
            begin
               if (retire)
               begin
                  state <= run ? S_FETCH_HI : S_IDLE;  // back to back fetch
               end
            end
            default:    state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == S_FETCH_LO)
      begin
         hi_byte <= mem_rdata;
      end
      if (state == S_READ)
      begin
         ops.instr <= cur_instr;
         ops.vx    <= vx_data;
         ops.vy    <= vy_data;
      end
   end

endmodule

/* logic/alu_unit.sv */
`timescale 1ns/100ps

module alu_unit (
   input  logic             clk,
   input  logic             arst_n,
   operand_if.exec          ops,
   output logic             alu_valid,
   output logic             res_we,
   output chip8_pkg::vidx_t res_idx,
   output chip8_pkg::byte_t res_data,
   output logic             flag_we,
   output chip8_pkg::byte_t flag_data,
   output logic             i_we,
   output chip8_pkg::addr_t i_data
);

   chip8_pkg::byte_t kk;
   logic [8:0]       sum;
   logic             wr;
   logic             fl;
   chip8_pkg::byte_t res;
   chip8_pkg::byte_t flag;

   assign kk  = ops.instr.imm.kk;
   assign sum = {1'b0, ops.vx} + {1'b0, ops.vy};

   always_comb
   begin
      wr   = 1'b0;
      fl   = 1'b0;
      res  = kk;
      flag = '0;
      case (ops.instr.nib.op)
         4'h6: wr = 1'b1;  // ld vx, kk
         4'h7:
         begin
            wr  = 1'b1;
            res = ops.vx + kk;  // no carry flag here
         end
         4'h8:
         begin
            wr = 1'b1;
            case (chip8_pkg::alu_op_e'(ops.instr.nib.n))
               chip8_pkg::ALU_MOV: res = ops.vy;
               chip8_pkg::ALU_OR:  res = ops.vx | ops.vy;
               chip8_pkg::ALU_AND: res = ops.vx & ops.vy;
               chip8_pkg::ALU_XOR: res = ops.vx ^ ops.vy;
               chip8_pkg::ALU_ADD:
               begin
                  fl   = 1'b1;
                  res  = sum[7:0];
                  flag = chip8_pkg::byte_t'(sum[8]);
               end
               chip8_pkg::ALU_SUB:
               begin
                  fl   = 1'b1;
                  res  = ops.vx - ops.vy;
                  flag = chip8_pkg::byte_t'(ops.vx >= ops.vy);  // no borrow
               end
               chip8_pkg::ALU_SHR:
               begin
                  fl   = 1'b1;
                  res  = ops.vy >> 1;
                  flag = chip8_pkg::byte_t'(ops.vy[0]);
               end
               chip8_pkg::ALU_SUBN:
               begin
                  fl   = 1'b1;
                  res  = ops.vy - ops.vx;
                  flag = chip8_pkg::byte_t'(ops.vy >= ops.vx);
               end
               chip8_pkg::ALU_SHL:
               begin
                  fl   = 1'b1;
                  res  = ops.vy << 1;
                  flag = chip8_pkg::byte_t'(ops.vy[7]);
               end
               default: wr = 1'b0;  // undefined 8xy codes retire as no-ops
            endcase
         end
         default: wr = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         alu_valid <= 1'b0;
         res_we    <= 1'b0;
         flag_we   <= 1'b0;
         i_we      <= 1'b0;
      end
      else
      begin
         alu_valid <= ops.issue;
         res_we    <= ops.issue & wr;
         flag_we   <= ops.issue & fl;
         i_we      <= ops.issue & (ops.instr.nib.op == 4'hA);
      end
   end

   always_ff @(posedge clk)
   begin
      if (ops.issue)
      begin
         res_idx   <= ops.instr.nib.x;
         res_data  <= res;
         flag_data <= flag;
         i_data    <= {ops.instr.imm.x, ops.instr.imm.kk};  // nnn
      end
   end

endmodule

/* logic/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
   input  logic             clk,
   input  logic             arst_n,
   operand_if.exec          ops,
   input  chip8_pkg::addr_t pc,
   output chip8_pkg::addr_t next_pc
);

   chip8_pkg::addr_t seq_pc;
   chip8_pkg::addr_t skip_pc;
   chip8_pkg::addr_t target;

   assign seq_pc  = pc + chip8_pkg::addr_t'(2);
   assign skip_pc = pc + chip8_pkg::addr_t'(4);

   always_comb
   begin
      case (ops.instr.nib.op)
         4'h1: target = {ops.instr.imm.x, ops.instr.imm.kk};  // jump nnn
         4'h3: target = (ops.vx == ops.instr.imm.kk) ? skip_pc : seq_pc;
         4'h4: target = (ops.vx != ops.instr.imm.kk) ? skip_pc : seq_pc;
         4'h5: target = (ops.vx == ops.vy) ? skip_pc : seq_pc;
         default: target = seq_pc;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         next_pc <= '0;
      end
      else if (ops.issue)
      begin
         next_pc <= target;  // held until the next issue
      end
   end

endmodule

/* logic/commit_unit.sv */
`timescale 1ns/100ps

`include "chip8_defs.svh"

module commit_unit (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             alu_valid,
   input  logic             res_we,
   input  chip8_pkg::vidx_t res_idx,
   input  chip8_pkg::byte_t res_data,
   input  logic             flag_we,
   input  chip8_pkg::byte_t flag_data,
   input  logic             i_we,
   input  chip8_pkg::addr_t i_data,
   input  chip8_pkg::addr_t next_pc,
   output logic             reg_we,
   output chip8_pkg::vidx_t reg_waddr,
   output chip8_pkg::byte_t reg_wdata,
   output chip8_pkg::addr_t pc,
   output chip8_pkg::addr_t i_reg,
   output logic             retire
);

   logic             flag_pend;  // second write cycle to VF
   chip8_pkg::byte_t flag_hold;

   // VF goes last so it overrides a result written to VF
   assign reg_we    = (alu_valid & res_we) | flag_pend;
   assign reg_waddr = flag_pend ? chip8_pkg::vidx_t'(`CHIP8_FLAG_REG) : res_idx;
   assign reg_wdata = flag_pend ? flag_hold : res_data;
   assign retire    = (alu_valid & ~flag_we) | flag_pend;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         flag_pend <= 1'b0;
         pc        <= `CHIP8_PC_RESET;
         i_reg     <= '0;
      end
      else
      begin
         flag_pend <= alu_valid & flag_we;
         if (retire)
         begin
            pc <= next_pc;  // pc moves only on the retire cycle
         end
         if (alu_valid & i_we)
         begin
            i_reg <= i_data;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (alu_valid & flag_we)
      begin
         flag_hold <= flag_data;
      end
   end

endmodule

/* logic/chip8_core.sv */
`timescale 1ns/100ps

`include "chip8_defs.svh"

module chip8_core (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      run,
   input  logic                      load_we,
   input  logic [`CHIP8_ADDR_W-1:0]  load_addr,
   input  logic [`CHIP8_DATA_W-1:0]  load_data,
   output logic [`CHIP8_ADDR_W-1:0]  pc,
   output logic [`CHIP8_ADDR_W-1:0]  i_reg,
   output logic                      reg_we,
   output logic [3:0]                reg_waddr,
   output logic [`CHIP8_DATA_W-1:0]  reg_wdata,
   output logic                      retire
);

   chip8_pkg::addr_t mem_raddr;
   chip8_pkg::byte_t mem_rdata;
   chip8_pkg::vidx_t vx_idx;
   chip8_pkg::vidx_t vy_idx;
   chip8_pkg::byte_t vx_data;
   chip8_pkg::byte_t vy_data;
   logic             alu_valid;
   logic             res_we;
   chip8_pkg::vidx_t res_idx;
   chip8_pkg::byte_t res_data;
   logic             flag_we;
   chip8_pkg::byte_t flag_data;
   logic             i_we;
   chip8_pkg::addr_t i_data;
   chip8_pkg::addr_t next_pc;

   operand_if ops ();

   program_mem u_mem (
      .clk(clk), .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
      .raddr(mem_raddr), .rdata(mem_rdata)
   );

   fetch_unit u_fetch (
      .clk(clk), .arst_n(arst_n), .run(run), .pc(pc), .retire(retire),
      .mem_raddr(mem_raddr), .mem_rdata(mem_rdata), .vx_idx(vx_idx), .vy_idx(vy_idx),
      .vx_data(vx_data), .vy_data(vy_data), .ops(ops.issuer)
   );

   reg_file u_regs (
      .clk(clk), .arst_n(arst_n), .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata),
      .raddr_a(vx_idx), .raddr_b(vy_idx), .rdata_a(vx_data), .rdata_b(vy_data)
   );

   alu_unit u_alu (
      .clk(clk), .arst_n(arst_n), .ops(ops.exec), .alu_valid(alu_valid),
      .res_we(res_we), .res_idx(res_idx), .res_data(res_data), .flag_we(flag_we),
      .flag_data(flag_data), .i_we(i_we), .i_data(i_data)
   );

   branch_unit u_branch (
      .clk(clk), .arst_n(arst_n), .ops(ops.exec), .pc(pc), .next_pc(next_pc)
   );

   commit_unit u_commit (
      .clk(clk), .arst_n(arst_n), .alu_valid(alu_valid), .res_we(res_we),
      .res_idx(res_idx), .res_data(res_data), .flag_we(flag_we), .flag_data(flag_data),
      .i_we(i_we), .i_data(i_data), .next_pc(next_pc), .reg_we(reg_we),
      .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .pc(pc), .i_reg(i_reg),
      .retire(retire)
   );

endmodule

/* sim/chip8_core_assert.sv */
`timescale 1ns/100ps

module chip8_core_assert (
   input logic             clk,
   input logic             arst_n,
   input logic             reg_we,
   input logic             retire,
   input chip8_pkg::addr_t pc
);

   // a write without retire is the result half of a flag op, VF follows
   write_near_retire: assert property (
      @(posedge clk) disable iff (!arst_n) (reg_we && !retire) |=> (reg_we && retire)
   ) else $error("register write outside a retire window");

   retire_single: assert property (
      @(posedge clk) disable iff (!arst_n) retire |=> !retire
   ) else $error("retire high on two cycles in a row");

   pc_moves_on_retire: assert property (
      @(posedge clk) disable iff (!arst_n) !$stable(pc) |-> $past(retire)
   ) else $error("pc changed without a retire");

endmodule

bind chip8_core chip8_core_assert u_assert (
   .clk(clk),
   .arst_n(arst_n),
   .reg_we(reg_we),
   .retire(retire),
   .pc(pc)
);

/* sim/tb_chip8_core.sv */
`timescale 1ns/100ps

`include "chip8_defs.svh"

module tb_chip8_core;

   logic             clk;
   logic             arst_n;
   logic             run;
   logic             load_we;
   chip8_pkg::addr_t load_addr;
   chip8_pkg::byte_t load_data;
   chip8_pkg::addr_t pc;
   chip8_pkg::addr_t i_reg;
   logic             reg_we;
   chip8_pkg::vidx_t reg_waddr;
   chip8_pkg::byte_t reg_wdata;
   logic             retire;

   chip8_pkg::byte_t vm [`CHIP8_NUM_V];  // reference V registers
   chip8_pkg::addr_t m_pc;
   chip8_pkg::addr_t m_i;
   chip8_pkg::addr_t last_pc;
   chip8_pkg::byte_t img [1 << `CHIP8_ADDR_W];  // copy of loaded program bytes

   logic [15:0]      prog_q [$];
   chip8_pkg::vidx_t wr_idx_q [$];
   chip8_pkg::byte_t wr_dat_q [$];

   integer seed = 24687;
   int     checks;
   int     errors;
   int     timeouts;

   localparam int RETIRE_TMO = 20;

   chip8_core DUT (
      .clk(clk), .arst_n(arst_n), .run(run), .load_we(load_we), .load_addr(load_addr),
      .load_data(load_data), .pc(pc), .i_reg(i_reg), .reg_we(reg_we),
      .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .retire(retire)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_byte(input string name, input chip8_pkg::byte_t want,
                             input chip8_pkg::byte_t got);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("ERR %s expected %h got %h", name, want, got);
      end
   endtask

   task automatic check_idx(input string name, input chip8_pkg::vidx_t want,
                            input chip8_pkg::vidx_t got);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("ERR %s expected %h got %h", name, want, got);
      end
   endtask

   task automatic check_addr(input string name, input chip8_pkg::addr_t want,
                             input chip8_pkg::addr_t got);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("ERR %s expected %h got %h", name, want, got);
      end
   endtask

   function automatic chip8_pkg::byte_t rand_byte();
      return chip8_pkg::byte_t'($random(seed));
   endfunction

   // address of the next word appended to the program
   function automatic chip8_pkg::addr_t here();
      return m_pc + 12'(2 * prog_q.size());
   endfunction

   function automatic void emit(input logic [15:0] word);
      prog_q.push_back(word);
   endfunction

   task automatic expect_wr(input chip8_pkg::vidx_t idx, input chip8_pkg::byte_t data);
      wr_idx_q.push_back(idx);
      wr_dat_q.push_back(data);
      vm[idx] = data;  // VF lands after the result
   endtask

   task automatic alu_model(input chip8_pkg::vidx_t x, input logic [3:0] n,
                            input chip8_pkg::byte_t vx, input chip8_pkg::byte_t vy);
      int s;
      s = int'(vx) + int'(vy);
      case (n)
         4'h0: expect_wr(x, vy);
         4'h1: expect_wr(x, vx | vy);
         4'h2: expect_wr(x, vx & vy);
         4'h3: expect_wr(x, vx ^ vy);
         4'h4:
         begin
            expect_wr(x, chip8_pkg::byte_t'(s));
            expect_wr(`CHIP8_FLAG_REG, (s > 255) ? 8'h01 : 8'h00);
         end
         4'h5:
         begin
            expect_wr(x, vx - vy);
            expect_wr(`CHIP8_FLAG_REG, (vx >= vy) ? 8'h01 : 8'h00);
         end
         4'h6:
         begin
            expect_wr(x, vy >> 1);
            expect_wr(`CHIP8_FLAG_REG, {7'b0, vy[0]});
         end
         4'h7:
         begin
            expect_wr(x, vy - vx);
            expect_wr(`CHIP8_FLAG_REG, (vy >= vx) ? 8'h01 : 8'h00);
         end
         4'hE:
         begin
            expect_wr(x, vy << 1);
            expect_wr(`CHIP8_FLAG_REG, {7'b0, vy[7]});
         end
         default: ;
      endcase
   endtask

   // predict one instruction and follow the DUT up to its retire
   task automatic step();
      chip8_pkg::instr_u w;
      chip8_pkg::byte_t  vx;
      chip8_pkg::byte_t  vy;
      chip8_pkg::addr_t  nxt;
      int                t;
      logic              done;
      if (timeouts > 0)
      begin
         return;
      end
      w       = {img[m_pc], img[m_pc + 12'd1]};
      vx      = vm[w.nib.x];
      vy      = vm[w.nib.y];
      nxt     = m_pc + 12'd2;
      last_pc = m_pc;
      case (w.nib.op)
         4'h1: nxt = {w.imm.x, w.imm.kk};
         4'h3: nxt = (vx == w.imm.kk) ? m_pc + 12'd4 : nxt;
         4'h4: nxt = (vx != w.imm.kk) ? m_pc + 12'd4 : nxt;
         4'h5: nxt = (vx == vy) ? m_pc + 12'd4 : nxt;
         4'h6: expect_wr(w.nib.x, w.imm.kk);
         4'h7: expect_wr(w.nib.x, vx + w.imm.kk);
         4'h8: alu_model(w.nib.x, w.nib.n, vx, vy);
         4'hA: m_i = {w.imm.x, w.imm.kk};
         default: ;  // dropped opcodes only advance pc
      endcase
      t    = 0;
      done = 1'b0;
      while (!done && t < RETIRE_TMO)
      begin
         @(negedge clk);
         t++;
         if (reg_we)
         begin
            if (wr_idx_q.size() == 0)
            begin
               errors++;
               $display("unexpected register write to V%h at pc %h", reg_waddr, last_pc);
            end
            else
            begin
               check_idx("reg_waddr", wr_idx_q.pop_front(), reg_waddr);
               check_byte("reg_wdata", wr_dat_q.pop_front(), reg_wdata);
            end
         end
         done = retire;
      end
      if (!done)
      begin
         timeouts++;
         $display("timeout: instruction at pc %h never retired", last_pc);
         return;
      end
      if (wr_idx_q.size() != 0)
      begin
         errors++;
         $display("%0d register write(s) missing at pc %h", wr_idx_q.size(), last_pc);
         wr_idx_q.delete();
         wr_dat_q.delete();
      end
      m_pc = nxt;
      @(negedge clk);
      check_addr("pc", m_pc, pc);
      check_addr("i_reg", m_i, i_reg);
   endtask

   task automatic write_byte(input chip8_pkg::addr_t a, input chip8_pkg::byte_t d);
      @(posedge clk);
      #1;
      load_we   = 1'b1;
      load_addr = a;
      load_data = d;
      img[a]    = d;
   endtask

   task automatic load_prog();
      chip8_pkg::addr_t a;
      a = m_pc;
      foreach (prog_q[k])
      begin
         write_byte(a, prog_q[k][15:8]);
         write_byte(a + 12'd1, prog_q[k][7:0]);
         a = a + 12'd2;
      end
      @(posedge clk);
      #1;
      load_we = 1'b0;
      prog_q.delete();
   endtask

   // program parks on a self jump before run drops and pc must hold
   task automatic run_prog();
      chip8_pkg::addr_t stop_pc;
      int               n;
      bit               busy;
      stop_pc = here();
      emit({4'h1, stop_pc});
      load_prog();
      run = 1'b1;
      n   = 0;
      while (last_pc != stop_pc && n < 64 && timeouts == 0)
      begin
         step();
         n++;
      end
      if (n >= 64)
      begin
         errors++;
         $display("program never reached its closing jump at %h", stop_pc);
      end
      @(posedge clk);
      #1;
      run = 1'b0;
      step();  // jump fetched before run fell
      busy = 1'b0;
      repeat (8)
      begin
         @(negedge clk);
         busy = busy | retire | reg_we;
      end
      if (busy)
      begin
         errors++;
         $display("core kept executing after run was lowered");
      end
      check_addr("pc", m_pc, pc);
   endtask

   task automatic imm_load_cases();
      for (int x = 0; x < 16; x++)
      begin
         emit({4'h6, 4'(x), rand_byte()});
      end
      run_prog();
   endtask

   task automatic imm_add_cases();
      emit(16'h61F0);
      emit(16'h7120);  // wraps past ff
      for (int k = 0; k < 6; k++)
      begin
         emit({4'h7, 4'(k + 2), rand_byte()});
      end
      run_prog();
   endtask

   task automatic alu_cases();
      logic [35:0]      codes;
      logic [3:0]       n;
      chip8_pkg::vidx_t x;
      chip8_pkg::vidx_t y;
      codes = 36'hE7654_3210;
      for (int k = 0; k < 9; k++)
      begin
         n = codes[4*k +: 4];
         x = 4'(k);
         y = 4'(k + 5);
         emit({4'h6, x, rand_byte()});
         emit({4'h6, y, rand_byte()});
         emit({4'h8, x, y, n});
         emit({4'h8, 4'hF, y, n});  // x = F
      end
      emit(16'h62FF);
      emit(16'h6301);
      emit(16'h8234);  // carry out
      emit(16'h6244);
      emit(16'h6344);
      emit(16'h8235);  // equal operands
      emit(16'h8237);
      run_prog();
   endtask

   task automatic branch_cases();
      chip8_pkg::addr_t target;
      emit(16'h6155);
      emit(16'h6255);
      emit(16'h6356);
      emit(16'h3155);  // taken
      emit(16'h6AEE);
      emit(16'h3154);
      emit(16'h4155);
      emit(16'h4154);  // taken
      emit(16'h6BEE);
      emit(16'h5120);  // taken
      emit(16'h6CEE);
      emit(16'h5130);
      target = here() + 12'd4;
      emit({4'h1, target});  // hop over one word
      emit(16'h6DEE);
      emit({4'h3, 4'h4, rand_byte()});
      emit(16'h6EEE);  // either outcome still reaches the closing jump
      run_prog();
   endtask

   task automatic index_cases();
      emit({4'hA, 12'($random(seed))});
      emit(16'hA123);
      run_prog();
   endtask

   task automatic dropped_cases();
      emit(16'hC1FF);
      emit(16'hF107);
      emit(16'h00E0);
      emit(16'h2400);
      emit(16'hD125);
      emit(16'hB300);
      emit(16'h9120);
      emit(16'hE19E);
      emit(16'hF533);
      run_prog();
   endtask

   initial
   begin
      arst_n    = 1'b0;
      run       = 1'b0;
      load_we   = 1'b0;
      load_addr = '0;
      load_data = '0;
      checks    = 0;
      errors    = 0;
      timeouts  = 0;
      m_pc      = `CHIP8_PC_RESET;
      m_i       = '0;
      last_pc   = '0;
      for (int i = 0; i < `CHIP8_NUM_V; i++)
      begin
         vm[i] = '0;
      end
      repeat (5) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(negedge clk);
      check_addr("pc", m_pc, pc);
      check_addr("i_reg", m_i, i_reg);
      if (retire || reg_we)
      begin
         errors++;
         $display("retire or reg_we high right after reset");
      end
      imm_load_cases();
      imm_add_cases();
      alu_cases();
      branch_cases();
      index_cases();
      dropped_cases();
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* chip8_core.f */
+incdir+logic
logic/chip8_pkg.sv
logic/operand_if.sv
logic/program_mem.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/commit_unit.sv
logic/chip8_core.sv
sim/chip8_core_assert.sv
sim/tb_chip8_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_chip8_core
FILELIST  = chip8_core.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf $(OBJDIR)
